/* dv/return_predictor_assertions.sv */
`timescale 1ns/1ps

module return_predictor_assertions
	import rv32i_types_pkg::*;
(
	input logic        CLK,
	input logic        nRST,
	input logic        stall,
	input logic        flush,
	input logic        reg_valid,
	input prediction_t prediction
);

	// failed assertion tally
	int fail_count = 0;

	// no prediction while in reset
	reset_quiet: assert property (
		@(posedge CLK) !nRST |-> !prediction.predict_taken
	) else begin
		$error("predict_taken high during reset");
		fail_count++;
	end

	// a prediction needs a live instruction in the register
	taken_needs_valid: assert property (
		@(posedge CLK) disable iff (!nRST)
		prediction.predict_taken |-> reg_valid
	) else begin
		$error("predict_taken high with no valid instruction");
		fail_count++;
	end

	// stall freezes register and stack unless flushed
	stall_holds: assert property (
		@(posedge CLK) disable iff (!nRST)
		(stall && !flush) |=> $stable(prediction)
	) else begin
		$error("prediction changed across a stall");
		fail_count++;
	end

	// return addresses are pc plus 4 of aligned pcs
	target_aligned: assert property (
		@(posedge CLK) disable iff (!nRST)
		prediction.predict_taken |-> (prediction.target_addr[1:0] == 2'b00)
	) else begin
		$error("predicted target not word aligned");
		fail_count++;
	end

endmodule

/* dv/return_predictor_tb.sv */
`timescale 1ns/1ps

module return_predictor_tb
	import rv32i_types_pkg::*;
();

	localparam int ENTRIES        = 4;
	localparam int TIMEOUT_CYCLES = 100;
	localparam int RANDOM_CYCLES  = 300;

	logic        CLK;
	logic        nRST;
	logic        fetch_valid;
	word_t       fetch_instr;
	word_t       fetch_pc;
	logic        stall;
	logic        flush;
	prediction_t prediction;

	integer seed;
	int     checks;
	int     mismatch_errors;
	int     timeout_errors;
	int     assertion_errors;
	word_t  next_pc;

	// model of the fetch/execute register
	logic  m_valid;
	word_t m_instr;
	word_t m_pc;

	// model stack
	word_t m_mem [ENTRIES];
	int    m_ptr;
	int    m_count;

	tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(16)) clock_i (.CLK(CLK), .nRST(nRST));

	return_predictor #(.ENTRIES(ENTRIES)) return_predictor_i (
		.CLK         (CLK),
		.nRST        (nRST),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		.stall       (stall),
		.flush       (flush),
		.prediction  (prediction)
	);

	bind return_predictor return_predictor_assertions assertions_i (
		.CLK        (CLK),
		.nRST       (nRST),
		.stall      (stall),
		.flush      (flush),
		.reg_valid  (fetch_ex.valid),
		.prediction (prediction)
	);

	function automatic logic is_link(regidx_t r);
		return (r == LINK_REG_A) || (r == LINK_REG_B);
	endfunction

	// hint table written out from the RISC-V rules
	function automatic ras_op_t expected_action(word_t instr);
		logic rd_l;
		logic rs1_l;
		rd_l  = is_link(instr[11:7]);
		rs1_l = is_link(instr[19:15]);
		if (instr[6:0] == JAL) begin
			return rd_l ? RAS_PUSH : RAS_NONE;
		end
		if (instr[6:0] != JALR) begin
			return RAS_NONE;
		end
		if (!rd_l && rs1_l) begin
			return RAS_POP;
		end
		if (rd_l && !rs1_l) begin
			return RAS_PUSH;
		end
		if (rd_l && rs1_l) begin
			return (instr[11:7] == instr[19:15]) ? RAS_PUSH : RAS_POP_PUSH;
		end
		return RAS_NONE;
	endfunction

	// encoders with random filler immediates
	function automatic word_t make_jal(regidx_t rd);
		word_t imm;
		imm = $random(seed);
		return {imm[31:12], rd, JAL};
	endfunction

	function automatic word_t make_jalr(regidx_t rd, regidx_t rs1);
		word_t imm;
		imm = $random(seed);
		return {imm[31:20], rs1, 3'b000, rd, JALR};
	endfunction

	// OP or OP-IMM
	function automatic word_t make_alu(regidx_t rd, regidx_t rs1);
		word_t imm;
		imm = $random(seed);
		return {imm[31:20], rs1, imm[14:12], rd, imm[0] ? 7'b0110011 : 7'b0010011};
	endfunction

	// mostly link registers with the odd arbitrary one
	function automatic regidx_t pick_reg();
		word_t r;
		r = $random(seed);
		case (r[2:0])
			3'd0, 3'd1: return 5'd1;
			3'd2, 3'd3: return 5'd5;
			3'd4: return 5'd0;
			3'd5: return 5'd6;
			default: return r[12:8];
		endcase
	endfunction

	task automatic check_prediction();
		ras_op_t op;
		logic    exp_taken;
		word_t   exp_target;
		op         = expected_action(m_instr);
		exp_taken  = m_valid && (op == RAS_POP || op == RAS_POP_PUSH) && (m_count > 0);
		exp_target = m_mem[(m_ptr + ENTRIES - 1) % ENTRIES];
		checks++;
		assert (prediction.predict_taken === exp_taken) else begin
			$display("Error at %0t: predict_taken expected %0b, seen %0b",
				$time, exp_taken, prediction.predict_taken);
			mismatch_errors++;
		end
		if (exp_taken) begin
			assert (prediction.target_addr === exp_target) else begin
				$display("Error at %0t: target_addr expected %h, seen %h",
					$time, exp_target, prediction.target_addr);
				mismatch_errors++;
			end
		end
	endtask

	// what the coming rising edge does to stack and register
	task automatic apply_model_edge();
		ras_op_t op;
		int      top;
		op  = expected_action(m_instr);
		top = (m_ptr + ENTRIES - 1) % ENTRIES;
		if (m_valid && !stall) begin
			if (op == RAS_PUSH || (op == RAS_POP_PUSH && m_count == 0)) begin
				// oldest slot gets overwritten when full
				m_mem[m_ptr] = m_pc + 32'd4;
				m_ptr        = (m_ptr + 1) % ENTRIES;
				if (m_count < ENTRIES) begin
					m_count++;
				end
			end else if (op == RAS_POP && m_count > 0) begin
				m_ptr = top;
				m_count--;
			end else if (op == RAS_POP_PUSH) begin
				m_mem[top] = m_pc + 32'd4;
			end
		end
		if (flush) begin
			m_valid = 1'b0;
		end else if (!stall) begin
			m_valid = fetch_valid;
		end
		if (!stall) begin
			m_instr = fetch_instr;
			m_pc    = fetch_pc;
		end
	endtask

	// check, drive new inputs, advance model, then next falling edge
	task automatic drive_cycle(logic v, word_t instr, logic stl, logic fl);
		check_prediction();
		fetch_valid = v;
		fetch_instr = instr;
		fetch_pc    = next_pc;
		stall       = stl;
		flush       = fl;
		apply_model_edge();
		next_pc = next_pc + 32'd4;
		@(negedge CLK);
	endtask

	task automatic issue(word_t instr);
		drive_cycle(1'b1, instr, 1'b0, 1'b0);
	endtask

	// idle until the register is empty
	task automatic drain();
		int n;
		n = 0;
		while ((m_valid || return_predictor_i.fetch_ex.valid) && n < TIMEOUT_CYCLES) begin
			drive_cycle(1'b0, '0, 1'b0, 1'b0);
			n++;
		end
		if (m_valid || return_predictor_i.fetch_ex.valid) begin
			$display("timeout: pipeline did not empty within %0d cycles", TIMEOUT_CYCLES);
			timeout_errors++;
		end
	endtask

	initial begin
		int    n;
		word_t r;
		fetch_valid      = 1'b0;
		fetch_instr      = '0;
		fetch_pc         = '0;
		stall            = 1'b0;
		flush            = 1'b0;
		seed             = 98074;
		checks           = 0;
		mismatch_errors  = 0;
		timeout_errors   = 0;
		assertion_errors = 0;
		next_pc          = 32'h0000_1000;
		m_valid          = 1'b0;
		m_instr          = '0;
		m_pc             = '0;
		m_ptr            = 0;
		m_count          = 0;

		n = 0;
		while (!nRST && n < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			n++;
		end
		if (!nRST) begin
			$display("timeout: reset was never released");
			timeout_errors++;
		end else begin
			@(negedge CLK);
			// call then return
			issue(make_jal(5'd1));
			issue(make_jalr(5'd0, 5'd1));
			drain();
			// nested calls then one extra return on empty
			issue(make_jal(5'd5));
			issue(make_jalr(5'd1, 5'd6));
			issue(make_jalr(5'd1, 5'd1));
			repeat (4) issue(make_jalr(5'd0, 5'd1));
			drain();
			// overflow
			repeat (ENTRIES + 2) issue(make_jal(5'd1));
			repeat (ENTRIES + 1) issue(make_jalr(5'd0, 5'd5));
			drain();
			// pop then push swaps the top
			issue(make_jal(5'd1));
			issue(make_jal(5'd5));
			issue(make_jalr(5'd1, 5'd5));
			repeat (3) issue(make_jalr(5'd0, 5'd1));
			drain();
			// non link forms leave the stack alone
			issue(make_jal(5'd1));
			issue(make_jalr(5'd0, 5'd6));
			issue(make_jal(5'd0));
			issue(make_alu(5'd1, 5'd5));
			issue(make_alu(5'd5, 5'd1));
			issue(make_jalr(5'd0, 5'd1));
			drain();
			// stalled return pops once
			issue(make_jal(5'd1));
			issue(make_jal(5'd5));
			issue(make_jalr(5'd0, 5'd1));
			repeat (3) drive_cycle(1'b1, make_jal(5'd5), 1'b1, 1'b0);
			repeat (3) issue(make_jalr(5'd0, 5'd1));
			drain();
			// flushed calls alone and under stall
			issue(make_jal(5'd1));
			drive_cycle(1'b1, make_jal(5'd5), 1'b0, 1'b1);
			drive_cycle(1'b1, make_jal(5'd1), 1'b1, 1'b1);
			repeat (2) issue(make_jalr(5'd0, 5'd5));
			drain();
			// random mix with stall and flush
			repeat (RANDOM_CYCLES) begin
				r = $random(seed);
				case (r[1:0])
					2'd0: fetch_instr = make_jal(pick_reg());
					2'd3: fetch_instr = make_alu(pick_reg(), pick_reg());
					default: fetch_instr = make_jalr(pick_reg(), pick_reg());
				endcase
				drive_cycle(r[2] | r[3], fetch_instr, r[6:4] == 3'd0, r[10:7] == 4'd0);
			end
			drain();
		end

		assertion_errors = return_predictor_i.assertions_i.fail_count;
		$display("checks %0d, mismatch errors %0d, timeout errors %0d, assertion errors %0d",
			checks, mismatch_errors, timeout_errors, assertion_errors);
		if (mismatch_errors == 0 && timeout_errors == 0 && assertion_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic CLK,
	output logic nRST
);

	// free running clock
	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
	end

endmodule

/* project.f */
source/rv32i_types_pkg.sv
source/fetch_execute_reg.sv
source/link_classifier.sv
source/return_stack.sv
source/return_predictor.sv
dv/tb_clock.sv
dv/return_predictor_assertions.sv
dv/return_predictor_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the return predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module return_predictor_tb \
	-f project.f \
	-Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	echo "run ok"
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

/* source/fetch_execute_reg.sv */
`timescale 1ns/1ps

module fetch_execute_reg
	import rv32i_types_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  logic      fetch_valid,
	input  word_t     fetch_instr,
	input  word_t     fetch_pc,
	input  logic      stall,
	input  logic      flush,
	output fetch_ex_t fetch_ex
);

	// registered valid bit
	logic valid_q;

	// registered payload
	word_t instr_q;
	word_t pc_q;

	// valid bit
	// flush wins over stall, kills the held instruction
	// stall keeps whatever was there
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= fetch_valid;
		end
	end

	// payload
	// loads every unstalled edge, valid decides if it counts
	// on flush the stale payload stays but is masked by valid
	always_ff @(posedge CLK) begin
		if (!stall) begin
			instr_q <= fetch_instr;
			pc_q    <= fetch_pc;
		end
	end

	// pack up for classifier and stack
	always_comb begin
		fetch_ex.valid = valid_q;
		fetch_ex.instr = instr_q;
		fetch_ex.pc    = pc_q;
	end

endmodule

/* source/link_classifier.sv */
`timescale 1ns/1ps

module link_classifier
	import rv32i_types_pkg::*;
(
	input  word_t   instr,
	output ras_op_t ras_op
);

	// raw fields out of the instruction word
	logic [6:0] opcode;
	regidx_t    rd;
	regidx_t    rs1;

	// link hint flags
	logic rd_link;
	logic rs1_link;
	logic same_reg;

	// opcode class
	logic is_jal;
	logic is_jalr;

	// field extraction
	always_comb begin
		opcode = instr[OPCODE_MSB:OPCODE_LSB];
		rd     = instr[RD_MSB:RD_LSB];
		rs1    = instr[RS1_MSB:RS1_LSB];
	end

	// only x1 and x5 count as link registers
	assign rd_link  = (rd == LINK_REG_A) || (rd == LINK_REG_B);
	assign rs1_link = (rs1 == LINK_REG_A) || (rs1 == LINK_REG_B);

	// rs1 equal to rd decides push vs pop-push
	assign same_reg = (rs1 == rd);

	// compare against the enum values
	assign is_jal  = (opcode == JAL);
	assign is_jalr = (opcode == JALR);

	// hint table
	// jal:  link rd pushes, else nothing
	// jalr: !rd_link, rs1_link           -> pop
	//       rd_link, !rs1_link           -> push
	//       rd_link, rs1_link, same reg  -> push
	//       rd_link, rs1_link, diff reg  -> pop then push
	//       neither link                 -> nothing
	always_comb begin
		ras_op = RAS_NONE;
		if (is_jal) begin
			if (rd_link) begin
				ras_op = RAS_PUSH;
			end
		end else if (is_jalr) begin
			case ({rd_link, rs1_link})
				2'b01: ras_op = RAS_POP;
				2'b10: ras_op = RAS_PUSH;
				2'b11: ras_op = same_reg ? RAS_PUSH : RAS_POP_PUSH;
				default: ras_op = RAS_NONE;
			endcase
		end
	end

endmodule

/* source/return_predictor.sv */
`timescale 1ns/1ps

module return_predictor
	import rv32i_types_pkg::*;
#(
	parameter int ENTRIES = 4
) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic        fetch_valid,
	input  word_t       fetch_instr,
	input  word_t       fetch_pc,
	input  logic        stall,
	input  logic        flush,
	output prediction_t prediction
);

	// registered instruction from fetch
	fetch_ex_t fetch_ex;

	// decoded stack action for that instruction
	ras_op_t ras_op;

	// one cycle from fetch to here
	fetch_execute_reg u_fetch_execute_reg (
		.CLK         (CLK),
		.nRST        (nRST),
		.fetch_valid (fetch_valid),
		.fetch_instr (fetch_instr),
		.fetch_pc    (fetch_pc),
		.stall       (stall),
		.flush       (flush),
		.fetch_ex    (fetch_ex)
	);

	// pure decode, no state
	link_classifier u_link_classifier (
		.instr  (fetch_ex.instr),
		.ras_op (ras_op)
	);

	// prediction same cycle as the registered instruction
	return_stack #(
		.ENTRIES (ENTRIES)
	) u_return_stack (
		.CLK        (CLK),
		.nRST       (nRST),
		.valid      (fetch_ex.valid),
		.pc         (fetch_ex.pc),
		.ras_op     (ras_op),
		.stall      (stall),
		.prediction (prediction)
	);

endmodule

/* source/return_stack.sv */
`timescale 1ns/1ps

module return_stack
	import rv32i_types_pkg::*;
#(
	parameter int ENTRIES = 4
) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic        valid,
	input  word_t       pc,
	input  ras_op_t     ras_op,
	input  logic        stall,
	output prediction_t prediction
);

	// pointer wraps for free with power of two depth
	localparam int PTR_W = $clog2(ENTRIES);
	// count needs one more state for full
	localparam int CNT_W = $clog2(ENTRIES + 1);

	// return address storage
	word_t stack_mem [ENTRIES];

	// write pointer, next free slot
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_next;
	// youngest valid entry sits one below ptr
	logic [PTR_W-1:0] top_idx;

	// occupancy, saturates at ENTRIES
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	// decoded conditions
	logic fire;
	logic has_entry;
	logic is_full;
	logic wants_pop;

	// memory write port
	logic             wr_en;
	logic [PTR_W-1:0] wr_idx;
	word_t            ret_addr;

	// only update once per instruction, not while stalled
	assign fire      = valid && !stall;
	assign has_entry = (count != '0);
	assign is_full   = (count == CNT_W'(ENTRIES));
	assign wants_pop = (ras_op == RAS_POP) || (ras_op == RAS_POP_PUSH);
	assign top_idx   = ptr - 1'b1;
	// address after the call
	assign ret_addr  = pc + 32'd4;

	// prediction is combinational off the held instruction
	// stays put through a stall since nothing below moves
	always_comb begin
		prediction.predict_taken = valid && wants_pop && has_entry;
		prediction.target_addr   = stack_mem[top_idx];
	end

	// next pointer, count and write
	always_comb begin
		ptr_next   = ptr;
		count_next = count;
		wr_en      = 1'b0;
		wr_idx     = ptr;
		if (fire) begin
			case (ras_op)
				RAS_PUSH: begin
					// overflow drops the oldest by overwriting it
					wr_en      = 1'b1;
					wr_idx     = ptr;
					ptr_next   = ptr + 1'b1;
					count_next = is_full ? count : count + 1'b1;
				end
				RAS_POP: begin
					// empty pop is a no-op
					if (has_entry) begin
						ptr_next   = top_idx;
						count_next = count - 1'b1;
					end
				end
				RAS_POP_PUSH: begin
					if (has_entry) begin
						// replace top in place
						wr_en  = 1'b1;
						wr_idx = top_idx;
					end else begin
						// nothing to pop, still record the call
						wr_en      = 1'b1;
						wr_idx     = ptr;
						ptr_next   = ptr + 1'b1;
						count_next = count + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// control state
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr   <= '0;
			count <= '0;
		end else begin
			ptr   <= ptr_next;
			count <= count_next;
		end
	end

	// storage, count decides what is live
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			stack_mem[wr_idx] <= ret_addr;
		end
	end

endmodule

/* source/rv32i_types_pkg.sv */
package rv32i_types_pkg;

	// basic widths
	// one instruction or one address
	typedef logic [31:0] word_t;

	// register index for rd and rs1
	typedef logic [4:0] regidx_t;

	// instruction field positions
	// opcode in the low seven bits
	localparam int OPCODE_LSB = 0;
	localparam int OPCODE_MSB = 6;

	// destination register field
	localparam int RD_LSB = 7;
	localparam int RD_MSB = 11;

	// first source register field
	localparam int RS1_LSB = 15;
	localparam int RS1_MSB = 19;

	// major opcodes the predictor cares about
	// anything else decodes as OTHER
	typedef enum logic [6:0] {
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		OTHER = 7'b0000000
	} opcode_t;

	// link registers per the hint table
	// x1 is ra, x5 is the alternate link t0
	localparam regidx_t LINK_REG_A = 5'd1;
	localparam regidx_t LINK_REG_B = 5'd5;

	// stack action from the classifier
	typedef enum logic [1:0] {
		RAS_NONE     = 2'b00,
		RAS_PUSH     = 2'b01,
		RAS_POP      = 2'b10,
		RAS_POP_PUSH = 2'b11
	} ras_op_t;

	// one instruction held between fetch and execute
	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc;
	} fetch_ex_t;

	// prediction seen by the rest of the core
	// target only meaningful with predict_taken high
	typedef struct packed {
		logic  predict_taken;
		word_t target_addr;
	} prediction_t;

endpackage
